//--- controller_standby_dp.f
tti_pkg.sv
standby_pkg.sv
i2c_byte_lane_if.sv
word_to_byte_conv.sv
byte_to_word_conv.sv
standby_tti_mux.sv
controller_standby_dp.sv
controller_standby_dp_sva.sv
tb_controller_standby_dp.sv

//--- tb_controller_standby_dp.sv
// Mode is changed only while both converters are idle; run is capped at 4000 cycles
`timescale 1ns/1ns

module tb_controller_standby_dp;
  import tti_pkg::*;

  localparam int unsigned NumWords = 40;
  localparam int unsigned MaxCycles = 4000;

  logic      clk_i;
  logic      rst_ni;
  logic      i3c_active_en_i, i3c_standby_en_i;
  logic      i2c_rx_valid_i, i2c_rx_ready_o, i2c_tx_valid_o, i2c_tx_ready_i;
  tti_word_t i2c_rx_data_i, i2c_tx_data_o;
  logic      i3c_rx_valid_i, i3c_rx_flush_i, i3c_rx_ready_o;
  tti_byte_t i3c_rx_data_i, i3c_tx_data_o;
  logic      i3c_tx_ready_i, i3c_tx_flush_i, i3c_tx_valid_o;
  logic      rx_queue_wvalid_o, rx_queue_wready_i, rx_queue_flush_o;
  tti_byte_t rx_queue_wdata_o, tx_queue_rdata_i;
  logic      tx_queue_rvalid_i, tx_queue_rready_o, tx_queue_flush_o;
  logic      ibi_queue_rvalid_i, ibi_queue_rready_o, i3c_ibi_ready_i, i3c_ibi_valid_o;
  logic      parity_err_i, get_status_done_i, err_o;

  logic [31:0] rng;
  int unsigned errors;
  int unsigned cycles;
  int unsigned rx_got;
  int unsigned tx_got;
  tti_byte_t   rx_exp[$];
  tti_word_t   tx_exp[$];

  controller_standby_dp dut0 (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Lane k of a word, lane 0 in bits 7:0
  function automatic tti_byte_t lane_of(input tti_word_t w, input int k);
    return tti_byte_t'(w >> (8 * k));
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp_v, act_v);
    end
  endtask

  // Compares the I2C-mode streams against the expected queues
  always @(posedge clk_i) begin
    if (rst_ni && !i3c_active_en_i && !i3c_standby_en_i) begin
      // Serializer takes a word once the last pending byte goes out
      check_val("i2c_rx_ready_o",
                (rx_exp.size() == 0) || (rx_exp.size() == 1 && rx_queue_wready_i),
                i2c_rx_ready_o);
      check_val("rx_queue_wvalid_o", rx_exp.size() != 0, rx_queue_wvalid_o);
      if (rx_queue_wvalid_o && rx_queue_wready_i) begin
        if (rx_exp.size() == 0) begin
          errors++;
          $display("RX queue received a byte that was never sent, t=%0t", $time);
        end else begin
          check_val("rx_queue_wdata_o", rx_exp.pop_front(), rx_queue_wdata_o);
        end
        rx_got++;
      end
      if (i2c_rx_valid_i && i2c_rx_ready_o) begin
        for (int k = 0; k < 4; k++) begin
          rx_exp.push_back(lane_of(i2c_rx_data_i, k));
        end
      end
      if (i2c_tx_valid_o && i2c_tx_ready_i) begin
        if (tx_exp.size() == 0) begin
          errors++;
          $display("I2C TX produced a word that was never sent, t=%0t", $time);
        end else begin
          check_val("i2c_tx_data_o", tx_exp.pop_front(), i2c_tx_data_o);
        end
        tx_got++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: run did not finish within %0d cycles", MaxCycles);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int unsigned sent;
    int unsigned lane;
    tti_word_t   acc;
    logic [31:0] r;

    clk_i = 1'b0;
    rng = 32'h7263d7e9;
    errors = 0;
    cycles = 0;
    rx_got = 0;
    tx_got = 0;
    rst_ni <= 1'b0;
    i3c_active_en_i <= 1'b0;
    i3c_standby_en_i <= 1'b0;
    i2c_rx_valid_i <= 1'b0;
    i2c_rx_data_i <= '0;
    i2c_tx_ready_i <= 1'b0;
    i3c_rx_valid_i <= 1'b0;
    i3c_rx_data_i <= '0;
    i3c_rx_flush_i <= 1'b0;
    i3c_tx_ready_i <= 1'b0;
    i3c_tx_flush_i <= 1'b0;
    rx_queue_wready_i <= 1'b0;
    tx_queue_rvalid_i <= 1'b0;
    tx_queue_rdata_i <= '0;
    ibi_queue_rvalid_i <= 1'b0;
    i3c_ibi_ready_i <= 1'b0;
    parity_err_i <= 1'b0;
    get_status_done_i <= 1'b0;

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_val("err_o", 0, err_o);

    // RX words into bytes with queue stalls
    sent = 0;
    i2c_rx_valid_i <= 1'b1;
    i2c_rx_data_i <= next_rand();
    while (rx_got < NumWords * 4) begin
      @(posedge clk_i);
      if (i2c_rx_valid_i && i2c_rx_ready_o) begin
        sent++;
        if (sent < NumWords) begin
          i2c_rx_data_i <= next_rand();
        end else begin
          i2c_rx_valid_i <= 1'b0;
        end
      end
      rx_queue_wready_i <= (next_rand() % 4) != 0;
    end

    // TX bytes into words with engine stalls
    sent = 0;
    lane = 0;
    acc = '0;
    tx_queue_rvalid_i <= 1'b1;
    tx_queue_rdata_i <= tti_byte_t'(next_rand());
    while (tx_got < NumWords) begin
      @(posedge clk_i);
      if (tx_queue_rvalid_i && tx_queue_rready_o) begin
        acc[8 * lane +: 8] = tx_queue_rdata_i;
        lane++;
        if (lane == 4) begin
          tx_exp.push_back(acc);
          lane = 0;
        end
        sent++;
        if (sent < NumWords * 4) begin
          tx_queue_rdata_i <= tti_byte_t'(next_rand());
        end else begin
          tx_queue_rvalid_i <= 1'b0;
        end
      end
      i2c_tx_ready_i <= (next_rand() % 3) != 0;
    end
    i2c_tx_ready_i <= 1'b0;

    // IBI gating and idle flushes in I2C mode
    repeat (20) begin
      @(posedge clk_i);
      check_val("ibi_queue_rready_o", 0, ibi_queue_rready_o);
      check_val("i3c_ibi_valid_o", 0, i3c_ibi_valid_o);
      check_val("tx_queue_flush_o", 0, tx_queue_flush_o);
      check_val("rx_queue_flush_o", 0, rx_queue_flush_o);
      r = next_rand();
      ibi_queue_rvalid_i <= r[0];
      i3c_ibi_ready_i <= r[1];
      i3c_tx_flush_i <= r[2];
      i3c_rx_flush_i <= r[3];
    end

    // I3C pass-through, checked against the inputs of the previous edge
    i3c_active_en_i <= 1'b1;
    @(posedge clk_i);
    repeat (60) begin
      @(posedge clk_i);
      check_val("rx_queue_wvalid_o", i3c_rx_valid_i, rx_queue_wvalid_o);
      check_val("rx_queue_wdata_o", i3c_rx_data_i, rx_queue_wdata_o);
      check_val("rx_queue_flush_o", i3c_rx_flush_i, rx_queue_flush_o);
      check_val("i3c_rx_ready_o", rx_queue_wready_i, i3c_rx_ready_o);
      check_val("tx_queue_rready_o", i3c_tx_ready_i, tx_queue_rready_o);
      check_val("tx_queue_flush_o", i3c_tx_flush_i, tx_queue_flush_o);
      check_val("i3c_tx_valid_o", tx_queue_rvalid_i, i3c_tx_valid_o);
      check_val("i3c_tx_data_o", tx_queue_rdata_i, i3c_tx_data_o);
      check_val("i3c_ibi_valid_o", ibi_queue_rvalid_i, i3c_ibi_valid_o);
      check_val("ibi_queue_rready_o", i3c_ibi_ready_i, ibi_queue_rready_o);
      check_val("i2c_tx_valid_o", 0, i2c_tx_valid_o);
      r = next_rand();
      i3c_active_en_i <= r[10];
      i3c_standby_en_i <= ~r[10];
      i3c_rx_valid_i <= r[0];
      i3c_rx_data_i <= r[15:8];
      i3c_rx_flush_i <= r[1];
      rx_queue_wready_i <= r[2];
      i3c_tx_ready_i <= r[3];
      i3c_tx_flush_i <= r[4];
      tx_queue_rvalid_i <= r[5];
      tx_queue_rdata_i <= r[23:16];
      ibi_queue_rvalid_i <= r[6];
      i3c_ibi_ready_i <= r[7];
    end

    // Sticky error flag
    @(posedge clk_i);
    parity_err_i <= 1'b1;
    @(posedge clk_i);
    parity_err_i <= 1'b0;
    @(posedge clk_i);
    check_val("err_o", 1, err_o);
    get_status_done_i <= 1'b1;
    @(posedge clk_i);
    get_status_done_i <= 1'b0;
    @(posedge clk_i);
    check_val("err_o", 0, err_o);
    parity_err_i <= 1'b1;
    @(posedge clk_i);
    get_status_done_i <= 1'b1;
    @(posedge clk_i);
    parity_err_i <= 1'b0;
    get_status_done_i <= 1'b0;
    @(posedge clk_i);
    check_val("err_o", 0, err_o);

    if (rx_exp.size() != 0 || tx_exp.size() != 0) begin
      errors++;
      $display("Expected data left unreceived at end of run");
    end
    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- controller_standby_dp_sva.sv
// Bound into standby_tti_mux; assumes the mode does not change while a byte is pending
`timescale 1ns/1ns

module controller_standby_dp_sva (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       i3c_active_en_i,
  input logic       i3c_standby_en_i,
  input logic       rx_queue_wvalid_i,
  input logic [7:0] rx_queue_wdata_i,
  input logic       rx_queue_wready_i,
  input logic       ibi_queue_rready_i,
  input logic       tx_queue_flush_i,
  input logic       get_status_done_i,
  input logic       err_i
);

  logic i2c_mode;

  // Mode taken from the enable pins
  assign i2c_mode = !(i3c_active_en_i || i3c_standby_en_i);

  // Serializer byte holds while the RX queue stalls
  rx_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (i2c_mode && rx_queue_wvalid_i && !rx_queue_wready_i) |=>
      (rx_queue_wvalid_i && $stable(rx_queue_wdata_i)))
    else $error("RX byte changed under back-pressure");

  ibi_gate_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    i2c_mode |-> !ibi_queue_rready_i)
    else $error("IBI queue read in I2C mode");

  tx_flush_gate_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    i2c_mode |-> !tx_queue_flush_i)
    else $error("TX flush in I2C mode");

  // Status read clears the flag, even with a parity error
  err_clear_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    get_status_done_i |=> !err_i)
    else $error("Error flag not cleared by status read");

endmodule

bind standby_tti_mux controller_standby_dp_sva sva0 (
  .clk_i              (clk_i),
  .rst_ni             (rst_ni),
  .i3c_active_en_i    (i3c_active_en_i),
  .i3c_standby_en_i   (i3c_standby_en_i),
  .rx_queue_wvalid_i  (rx_queue_wvalid_o),
  .rx_queue_wdata_i   (rx_queue_wdata_o),
  .rx_queue_wready_i  (rx_queue_wready_i),
  .ibi_queue_rready_i (ibi_queue_rready_o),
  .tx_queue_flush_i   (tx_queue_flush_o),
  .get_status_done_i  (get_status_done_i),
  .err_i              (err_o)
);

//--- controller_standby_dp.sv
// Engines are external; I2C side is word wide, queues are byte wide, no flush on the I2C path
`timescale 1ns/1ns

module controller_standby_dp (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                i3c_active_en_i,
  input  logic                i3c_standby_en_i,

  // I2C engine words
  input  logic                i2c_rx_valid_i,
  input  tti_pkg::tti_word_t  i2c_rx_data_i,
  output logic                i2c_rx_ready_o,
  output logic                i2c_tx_valid_o,
  output tti_pkg::tti_word_t  i2c_tx_data_o,
  input  logic                i2c_tx_ready_i,

  // I3C engine bytes
  input  logic                i3c_rx_valid_i,
  input  tti_pkg::tti_byte_t  i3c_rx_data_i,
  input  logic                i3c_rx_flush_i,
  output logic                i3c_rx_ready_o,
  input  logic                i3c_tx_ready_i,
  input  logic                i3c_tx_flush_i,
  output logic                i3c_tx_valid_o,
  output tti_pkg::tti_byte_t  i3c_tx_data_o,

  // RX data queue
  output logic                rx_queue_wvalid_o,
  output tti_pkg::tti_byte_t  rx_queue_wdata_o,
  input  logic                rx_queue_wready_i,
  output logic                rx_queue_flush_o,

  // TX data queue
  input  logic                tx_queue_rvalid_i,
  input  tti_pkg::tti_byte_t  tx_queue_rdata_i,
  output logic                tx_queue_rready_o,
  output logic                tx_queue_flush_o,

  // IBI queue
  input  logic                ibi_queue_rvalid_i,
  output logic                ibi_queue_rready_o,
  input  logic                i3c_ibi_ready_i,
  output logic                i3c_ibi_valid_o,

  input  logic                parity_err_i,
  input  logic                get_status_done_i,
  output logic                err_o
);

  i2c_byte_lane_if lane ();

  // 32 to 8 toward the RX queue
  word_to_byte_conv u_rx_ser (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .word_valid_i (i2c_rx_valid_i),
    .word_data_i  (i2c_rx_data_i),
    .word_ready_o (i2c_rx_ready_o),
    .lane_o       (lane.ser)
  );

  // 8 to 32 from the TX queue
  byte_to_word_conv u_tx_pack (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lane_i       (lane.pack),
    .word_valid_o (i2c_tx_valid_o),
    .word_data_o  (i2c_tx_data_o),
    .word_ready_i (i2c_tx_ready_i)
  );

  standby_tti_mux u_mux (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .i3c_active_en_i    (i3c_active_en_i),
    .i3c_standby_en_i   (i3c_standby_en_i),
    .lane_i             (lane.mux),
    .i3c_rx_valid_i     (i3c_rx_valid_i),
    .i3c_rx_data_i      (i3c_rx_data_i),
    .i3c_rx_flush_i     (i3c_rx_flush_i),
    .i3c_rx_ready_o     (i3c_rx_ready_o),
    .i3c_tx_ready_i     (i3c_tx_ready_i),
    .i3c_tx_flush_i     (i3c_tx_flush_i),
    .i3c_tx_valid_o     (i3c_tx_valid_o),
    .i3c_tx_data_o      (i3c_tx_data_o),
    .rx_queue_wvalid_o  (rx_queue_wvalid_o),
    .rx_queue_wdata_o   (rx_queue_wdata_o),
    .rx_queue_wready_i  (rx_queue_wready_i),
    .rx_queue_flush_o   (rx_queue_flush_o),
    .tx_queue_rvalid_i  (tx_queue_rvalid_i),
    .tx_queue_rdata_i   (tx_queue_rdata_i),
    .tx_queue_rready_o  (tx_queue_rready_o),
    .tx_queue_flush_o   (tx_queue_flush_o),
    .ibi_queue_rvalid_i (ibi_queue_rvalid_i),
    .ibi_queue_rready_o (ibi_queue_rready_o),
    .i3c_ibi_ready_i    (i3c_ibi_ready_i),
    .i3c_ibi_valid_o    (i3c_ibi_valid_o),
    .parity_err_i       (parity_err_i),
    .get_status_done_i  (get_status_done_i),
    .err_o              (err_o)
  );

endmodule

//--- standby_tti_mux.sv
// Mode switches are not synchronized to transfers; change mode only while both streams are idle
`timescale 1ns/1ns

module standby_tti_mux (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                i3c_active_en_i,
  input  logic                i3c_standby_en_i,

  i2c_byte_lane_if.mux        lane_i,

  // I3C engine RX
  input  logic                i3c_rx_valid_i,
  input  tti_pkg::tti_byte_t  i3c_rx_data_i,
  input  logic                i3c_rx_flush_i,
  output logic                i3c_rx_ready_o,

  // I3C engine TX
  input  logic                i3c_tx_ready_i,
  input  logic                i3c_tx_flush_i,
  output logic                i3c_tx_valid_o,
  output tti_pkg::tti_byte_t  i3c_tx_data_o,

  // RX data queue
  output logic                rx_queue_wvalid_o,
  output tti_pkg::tti_byte_t  rx_queue_wdata_o,
  input  logic                rx_queue_wready_i,
  output logic                rx_queue_flush_o,

  // TX data queue
  input  logic                tx_queue_rvalid_i,
  input  tti_pkg::tti_byte_t  tx_queue_rdata_i,
  output logic                tx_queue_rready_o,
  output logic                tx_queue_flush_o,

  // IBI queue
  input  logic                ibi_queue_rvalid_i,
  output logic                ibi_queue_rready_o,
  input  logic                i3c_ibi_ready_i,
  output logic                i3c_ibi_valid_o,

  input  logic                parity_err_i,
  input  logic                get_status_done_i,
  output logic                err_o
);
  import standby_pkg::*;

  bus_mode_t mode;
  logic      is_i3c;

  assign mode   = bus_mode_t'(i3c_active_en_i | i3c_standby_en_i);
  assign is_i3c = (mode == ModeI3c);

  always_comb begin
    // RX queue write side
    rx_queue_wvalid_o = is_i3c ? i3c_rx_valid_i : lane_i.rx_valid;
    rx_queue_wdata_o  = is_i3c ? i3c_rx_data_i : lane_i.rx_data;
    rx_queue_flush_o  = is_i3c & i3c_rx_flush_i;
    i3c_rx_ready_o    = is_i3c & rx_queue_wready_i;
    lane_i.rx_ready   = ~is_i3c & rx_queue_wready_i;

    // TX queue read side
    tx_queue_rready_o = is_i3c ? i3c_tx_ready_i : lane_i.tx_ready;
    tx_queue_flush_o  = is_i3c & i3c_tx_flush_i;
    i3c_tx_valid_o    = is_i3c & tx_queue_rvalid_i;
    i3c_tx_data_o     = tx_queue_rdata_i;
    lane_i.tx_valid   = ~is_i3c & tx_queue_rvalid_i;
    lane_i.tx_data    = tx_queue_rdata_i;

    // IBI only exists on I3C
    i3c_ibi_valid_o    = is_i3c & ibi_queue_rvalid_i;
    ibi_queue_rready_o = is_i3c & i3c_ibi_ready_i;
  end

  // Sticky error, status read has priority
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_o <= 1'b0;
    end else if (get_status_done_i) begin
      err_o <= 1'b0;
    end else if (parity_err_i) begin
      err_o <= 1'b1;
    end
  end

endmodule

//--- byte_to_word_conv.sv
// First byte lands in lane 0; a partial word is held until four bytes have arrived
`timescale 1ns/1ns

module byte_to_word_conv (
  input  logic                clk_i,
  input  logic                rst_ni,
  i2c_byte_lane_if.pack       lane_i,
  output logic                word_valid_o,
  output tti_pkg::tti_word_t  word_data_o,
  input  logic                word_ready_i
);
  import tti_pkg::*;

  localparam byte_idx_t LastLane = byte_idx_t'(BytesPerWord - 1);

  tti_word_t word_q;
  byte_idx_t lane_q;
  logic      full_q;

  logic      byte_fire;
  logic      word_fire;

  assign word_fire = full_q & word_ready_i;

  // Room for a byte unless full and stalled
  assign lane_i.tx_ready = ~full_q | word_ready_i;
  assign byte_fire       = lane_i.tx_valid & lane_i.tx_ready;

  assign word_valid_o = full_q;
  assign word_data_o  = word_q;

  // Lane counter wraps to 0 as the word fills
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
      lane_q <= '0;
    end else begin
      if (byte_fire) begin
        lane_q <= lane_q + 1'b1;
      end
      if (byte_fire && (lane_q == LastLane)) begin
        full_q <= 1'b1;
      end else if (word_fire) begin
        full_q <= 1'b0;
      end
    end
  end

  // Lane 0 may be overwritten in the cycle the full word leaves
  always_ff @(posedge clk_i) begin
    if (byte_fire) begin
      word_q[lane_q * $bits(tti_byte_t) +: $bits(tti_byte_t)] <= lane_i.tx_data;
    end
  end

endmodule

//--- word_to_byte_conv.sv
// Sends lane 0 first; no flush, a started word always drains all four bytes
`timescale 1ns/1ns

module word_to_byte_conv (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                word_valid_i,
  input  tti_pkg::tti_word_t  word_data_i,
  output logic                word_ready_o,
  i2c_byte_lane_if.ser        lane_o
);
  import tti_pkg::*;

  localparam byte_idx_t LastLane = byte_idx_t'(BytesPerWord - 1);

  tti_word_t word_q;
  byte_idx_t lane_q;
  logic      busy_q;

  logic      byte_fire;
  logic      last_byte;
  logic      word_fire;

  assign byte_fire = busy_q & lane_o.rx_ready;
  assign last_byte = (lane_q == LastLane);

  // Next word may enter while the last byte leaves
  assign word_ready_o = ~busy_q | (byte_fire & last_byte);
  assign word_fire    = word_valid_i & word_ready_o;

  assign lane_o.rx_valid = busy_q;
  assign lane_o.rx_data  = word_q[lane_q * $bits(tti_byte_t) +: $bits(tti_byte_t)];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      lane_q <= '0;
    end else begin
      if (word_fire) begin
        busy_q <= 1'b1;
        lane_q <= '0;
      end else if (byte_fire && last_byte) begin
        busy_q <= 1'b0;
        lane_q <= '0;
      end else if (byte_fire) begin
        lane_q <= lane_q + 1'b1;
      end
    end
  end

  // Word buffer
  always_ff @(posedge clk_i) begin
    if (word_fire) begin
      word_q <= word_data_i;
    end
  end

endmodule

//--- i2c_byte_lane_if.sv
// Byte streams only; both use valid/ready and hold valid and data until the transfer
`timescale 1ns/1ns

interface i2c_byte_lane_if;
  import tti_pkg::*;

  // Serializer toward the RX queue
  logic      rx_valid;
  tti_byte_t rx_data;
  logic      rx_ready;

  // TX queue toward the packer
  logic      tx_valid;
  tti_byte_t tx_data;
  logic      tx_ready;

  modport ser (
    output rx_valid,
    output rx_data,
    input  rx_ready
  );

  modport pack (
    input  tx_valid,
    input  tx_data,
    output tx_ready
  );

  modport mux (
    input  rx_valid,
    input  rx_data,
    output rx_ready,
    output tx_valid,
    output tx_data,
    input  tx_ready
  );

endinterface

//--- standby_pkg.sv
// Bus mode is a single bit; any other value than ModeI3c is treated as I2C
package standby_pkg;

  // 0 selects the I2C engine, 1 the I3C engine
  typedef logic bus_mode_t;

  localparam bus_mode_t ModeI3c = 1'b1;

endpackage

//--- tti_pkg.sv
// Queue data is byte wide; the I2C engine side uses 32-bit words packed little-endian
package tti_pkg;

  // One RX or TX queue data byte
  typedef logic [7:0] tti_byte_t;

  // One I2C engine data word
  typedef logic [31:0] tti_word_t;

  // Byte lanes per engine word
  localparam int unsigned BytesPerWord = $bits(tti_word_t) / $bits(tti_byte_t);

  // Lane 0 holds bits 7:0
  typedef logic [$clog2(BytesPerWord)-1:0] byte_idx_t;

endpackage
